// File: logic/rx_dma_defs.svh
// Receive DMA shared constants
// widths, tag range and completion decode codes
`ifndef RX_DMA_DEFS_SVH
`define RX_DMA_DEFS_SVH

// on-chip buffer address width, pointers carry one extra wrap bit
`define RX_BW 9

// tag index width, 8 outstanding reads
`define RX_OSRW 3

// upper tag bits owned by this block
`define RX_TAG_BASE 5'b00000

// completion with data, successful status
`define RX_CPLD_FMT_TYPE 7'b1001010
`define RX_CPL_SC 3'b000

// smallest read is 16 qw, doubled per max read request step up to 128
`define RX_MAX_QW_LOG 4

`endif

// File: logic/rx_dma_pkg.sv
// Receive DMA package
// completion beat decode and byte order helpers
package rx_dma_pkg;

    // one 64-bit TRN beat, seen raw or as one of the two header beats
    typedef union packed {
        logic [63:0] raw;
        struct packed {
            logic        rsv;
            logic [6:0]  fmt_type;
            logic [13:0] attr;       // tc, td/ep, attr bits
            logic [9:0]  len_dw;
            logic [15:0] cpl_id;
            logic [2:0]  status;
            logic        bcm;
            logic [11:0] byte_cnt;
        } hdr0;
        struct packed {
            logic [15:0] req_id;
            logic [7:0]  tag;
            logic        rsv;
            logic [6:0]  low_addr;
            logic [31:0] dw0;        // first payload dword
        } hdr1;
    } cpl_beat_u;

    function automatic logic [31:0] dw_swap(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    function automatic logic [63:0] qw_swap(input logic [63:0] q);
        return {dw_swap(q[63:32]), dw_swap(q[31:0])};
    endfunction

endpackage

// File: logic/rx_dma_if.sv
// Receive DMA internal interfaces
// alloc_if opens a slot per read, slot_if reads and writes back a slot
`include "rx_dma_defs.svh"

interface alloc_if;
    logic                 new_rq;    // one cycle per acknowledged read
    logic [`RX_OSRW-1:0]  tag;
    logic [`RX_BW:0]      base;      // buffer pointer of the first qw
    logic [8:0]           len_qw;
    logic [`RX_OSRW:0]    done_cnt;  // requests committed so far

    modport engine  (output new_rq, tag, base, len_qw, input done_cnt);
    modport tracker (input new_rq, tag, base, len_qw, output done_cnt);
endinterface

interface slot_if;
    logic [`RX_OSRW-1:0]  look_tag;
    logic                 upd;
    logic [`RX_BW:0]      upd_addr;
    logic [9:0]           upd_rcv;   // qw completed by this update
    logic [31:0]          upd_saved;
    logic                 upd_saved_en;
    logic                 done;      // end of completion
    logic [`RX_BW:0]      cur_addr;
    logic [31:0]          cur_saved;
    logic                 cur_saved_en;

    modport writer  (output look_tag, upd, upd_addr, upd_rcv, upd_saved, upd_saved_en, done,
                     input cur_addr, cur_saved, cur_saved_en);
    modport tracker (input look_tag, upd, upd_addr, upd_rcv, upd_saved, upd_saved_en, done,
                     output cur_addr, cur_saved, cur_saved_en);
endinterface

// File: logic/rd_req_engine.sv
// Read request engine
// walks one host buffer descriptor and issues memory reads of at most the
// maximum read request size, held back by the outstanding count and by
// free space in the on-chip buffer
`include "rx_dma_defs.svh"

module rd_req_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           cfg_max_rd_req_size,
    input  logic [63:0]          lbuf_addr,
    input  logic [31:0]          lbuf_len,   // quadwords
    input  logic                 lbuf_en,
    output logic                 lbuf_dn,
    input  logic [`RX_BW:0]      committed_cons,
    output logic [63:0]          hst_addr,
    output logic                 rd,
    output logic [8:0]           rd_qw,
    input  logic                 rd_ack,
    input  logic [`RX_OSRW-1:0]  rd_tag,
    alloc_if.engine              alloc
);
    localparam int PW     = `RX_BW + 1;
    localparam int MAX_OS = 1 << `RX_OSRW;

    localparam logic [2:0] E_IDLE  = 3'd0;
    localparam logic [2:0] E_CRED  = 3'd1;
    localparam logic [2:0] E_SIZE  = 3'd2;
    localparam logic [2:0] E_SPACE = 3'd3;
    localparam logic [2:0] E_RD    = 3'd4;
    localparam logic [2:0] E_GAP   = 3'd5;
    localparam logic [2:0] E_LAST  = 3'd6;

    logic [2:0]          state;
    logic [2:0]          mx_sel;
    logic [8:0]          mx_qw;
    logic [31:0]         len_reg;
    logic [31:0]         qw_cnt;
    logic [31:0]         qw_lft;
    logic [PW-1:0]       iprod;      // own producer, ahead of committed_prod
    logic [`RX_OSRW:0]   snt_rq;
    logic [`RX_OSRW:0]   os_req;
    logic [PW-1:0]       fill;
    logic [PW:0]         need;

    assign os_req = snt_rq - alloc.done_cnt;
    assign fill   = iprod - committed_cons;
    assign need   = {1'b0, fill} + (PW+1)'(rd_qw);   // fill level after this read

    // size setting and remaining length, one cycle behind
    always_ff @(posedge clk) begin
        mx_sel <= cfg_max_rd_req_size;
        mx_qw  <= 9'd1 << (`RX_MAX_QW_LOG + ((mx_sel > 3'd3) ? 3'd3 : mx_sel));
        qw_lft <= len_reg - qw_cnt;
    end

    //////////////////////////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= E_IDLE;
            rd           <= 1'b0;
            lbuf_dn      <= 1'b0;
            alloc.new_rq <= 1'b0;
            iprod        <= '0;
            snt_rq       <= '0;
        end else begin
            lbuf_dn      <= 1'b0;
            alloc.new_rq <= 1'b0;
            case (state)
                E_IDLE: begin
                    hst_addr <= lbuf_addr;
                    len_reg  <= lbuf_len;
                    qw_cnt   <= '0;
                    if (lbuf_en) state <= E_CRED;
                end
                E_CRED: if (os_req < MAX_OS) state <= E_SIZE;
                E_SIZE: begin
                    rd_qw <= (qw_lft > 32'(mx_qw)) ? mx_qw : qw_lft[8:0];
                    state <= E_SPACE;
                end
                E_SPACE: begin
                    if (need <= (PW+1)'(1 << `RX_BW)) begin   // waits for the consumer
                        rd    <= 1'b1;
                        state <= E_RD;
                    end
                end
                E_RD: begin
                    if (rd_ack) begin
                        rd           <= 1'b0;
                        alloc.new_rq <= 1'b1;
                        alloc.tag    <= rd_tag;
                        alloc.base   <= iprod;
                        alloc.len_qw <= rd_qw;
                        iprod        <= iprod + PW'(rd_qw);
                        hst_addr     <= hst_addr + (64'(rd_qw) << 3);
                        qw_cnt       <= qw_cnt + 32'(rd_qw);
                        snt_rq       <= snt_rq + 1'b1;
                        state        <= E_GAP;
                    end
                end
                E_GAP: state <= E_LAST;   // qw_lft catches up
                E_LAST: begin
                    if (qw_lft != '0) begin
                        state <= E_CRED;
                    end else begin
                        lbuf_dn <= 1'b1;
                        state   <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

// File: logic/cpl_filter.sv
// Completion filter
// spots completions with data and good status whose tag belongs to this
// block, and hands length and tag index to the writer
`include "rx_dma_defs.svh"

module cpl_filter
    import rx_dma_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [63:0]          trn_rd,
    input  logic                 trn_rsof_n,
    input  logic                 trn_rsrc_rdy_n,
    output logic                 cnsm,      // one cycle after the tag beat
    output logic [9:0]           tlp_len,   // dwords
    output logic [`RX_OSRW-1:0]  tlp_tag
);
    localparam logic [4:0] TAG_BASE = `RX_TAG_BASE;
    localparam logic       F_HDR0   = 1'b0;
    localparam logic       F_HDR1   = 1'b1;

    logic      state;
    cpl_beat_u beat;

    assign beat = cpl_beat_u'(trn_rd);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= F_HDR0;
            cnsm  <= 1'b0;
        end else begin
            cnsm <= 1'b0;
            case (state)
                F_HDR0: begin
                    if (!trn_rsrc_rdy_n && !trn_rsof_n) begin
                        tlp_len <= beat.hdr0.len_dw;
                        if (beat.hdr0.fmt_type == `RX_CPLD_FMT_TYPE &&
                            beat.hdr0.status == `RX_CPL_SC) state <= F_HDR1;
                    end
                end
                F_HDR1: begin
                    if (!trn_rsrc_rdy_n) begin
                        tlp_tag <= beat.hdr1.tag[`RX_OSRW-1:0];
                        if (beat.hdr1.tag[7:`RX_OSRW] == TAG_BASE) cnsm <= 1'b1;
                        state <= F_HDR0;   // foreign tags are dropped here
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/cpl_writer.sv
// Completion writer
// realigns the dword payload of a completion into quadword buffer writes,
// joining halves carried over from an earlier completion of the same tag
`include "rx_dma_defs.svh"

module cpl_writer
    import rx_dma_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [63:0]          trn_rd,
    input  logic                 trn_reof_n,
    input  logic                 trn_rsrc_rdy_n,
    input  logic                 cnsm,
    input  logic [9:0]           tlp_len,
    input  logic [`RX_OSRW-1:0]  tlp_tag,
    output logic                 wr_en,
    output logic [`RX_BW-1:0]    wr_addr,
    output logic [63:0]          wr_data,
    slot_if.writer               slot
);
    localparam int   PW     = `RX_BW + 1;
    localparam logic W_IDLE = 1'b0;
    localparam logic W_DATA = 1'b1;

    logic                 state;
    cpl_beat_u            beat_q;
    logic                 vld_q;
    logic                 eof_q;
    logic [`RX_OSRW-1:0]  tag_q;
    logic                 sv_mode;     // a saved half opened this completion
    logic                 odd_len;
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        nxt_addr_q;
    logic [9:0]           nxt_rcv_q;
    logic [9:0]           step;
    logic [31:0]          aux;         // even dword waiting for its partner

    assign slot.look_tag = cnsm ? tlp_tag : tag_q;
    assign step = 10'((11'(tlp_len) + 11'(slot.cur_saved_en)) >> 1);

    always_ff @(posedge clk) begin
        beat_q <= cpl_beat_u'(trn_rd);
        eof_q  <= !trn_reof_n;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= W_IDLE;
            vld_q     <= 1'b0;
            wr_en     <= 1'b0;
            slot.upd  <= 1'b0;
            slot.done <= 1'b0;
        end else begin
            vld_q     <= !trn_rsrc_rdy_n;
            wr_en     <= 1'b0;
            slot.upd  <= 1'b0;
            slot.done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (cnsm) begin   // beat_q holds the tag beat with p0
                        tag_q      <= tlp_tag;
                        sv_mode    <= slot.cur_saved_en;
                        odd_len    <= tlp_len[0];
                        nxt_addr_q <= slot.cur_addr + PW'(step);
                        nxt_rcv_q  <= step;
                        aux        <= beat_q.hdr1.dw0;
                        wr_ptr     <= slot.cur_addr + PW'(slot.cur_saved_en);
                        wr_en      <= slot.cur_saved_en;          // close the saved qw
                        wr_addr    <= slot.cur_addr[`RX_BW-1:0];
                        wr_data    <= {dw_swap(beat_q.hdr1.dw0), slot.cur_saved};
                        slot.upd   <= 1'b1;
                        if (eof_q) begin   // single dword payload
                            slot.done         <= 1'b1;
                            slot.upd_addr     <= slot.cur_addr + PW'(step);
                            slot.upd_rcv      <= step;
                            slot.upd_saved    <= dw_swap(beat_q.hdr1.dw0);
                            slot.upd_saved_en <= tlp_len[0] ^ slot.cur_saved_en;
                        end else begin     // start mark, slot unchanged
                            slot.upd_addr     <= slot.cur_addr;
                            slot.upd_rcv      <= '0;
                            slot.upd_saved    <= slot.cur_saved;
                            slot.upd_saved_en <= slot.cur_saved_en;
                            state             <= W_DATA;
                        end
                    end
                end
                W_DATA: begin
                    if (vld_q) begin
                        wr_en   <= !(eof_q && sv_mode && !odd_len);   // lone tail is saved
                        wr_addr <= wr_ptr[`RX_BW-1:0];
                        wr_data <= sv_mode ? qw_swap({beat_q.raw[31:0], beat_q.raw[63:32]})
                                           : qw_swap({beat_q.raw[63:32], aux});
                        wr_ptr  <= wr_ptr + 1'b1;
                        aux     <= beat_q.raw[31:0];
                        if (eof_q) begin
                            slot.upd          <= 1'b1;
                            slot.done         <= 1'b1;
                            slot.upd_addr     <= nxt_addr_q;
                            slot.upd_rcv      <= nxt_rcv_q;
                            slot.upd_saved    <= dw_swap(sv_mode ? beat_q.raw[63:32]
                                                                 : beat_q.raw[31:0]);
                            slot.upd_saved_en <= sv_mode ^ odd_len;
                            state             <= W_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/cpl_tracker.sv
// Completion tracker
// per-tag slot table; walks the tags in request order and moves the
// committed producer pointer as the oldest request fills
`include "rx_dma_defs.svh"

module cpl_tracker (
    input  logic              clk,
    input  logic              rst,
    output logic [`RX_BW:0]   committed_prod,
    alloc_if.tracker          alloc,
    slot_if.tracker           slot
);
    localparam int   PW       = `RX_BW + 1;
    localparam int   NTAG     = 1 << `RX_OSRW;
    localparam logic C_WAIT   = 1'b0;
    localparam logic C_RETIRE = 1'b1;

    logic [PW-1:0]        st_ptr  [NTAG];
    logic [PW-1:0]        wr_ptr  [NTAG];
    logic [8:0]           rq_len  [NTAG];
    logic [9:0]           rcv_len [NTAG];
    logic [31:0]          saved   [NTAG];
    logic [NTAG-1:0]      saved_en;
    logic [NTAG-1:0]      ready;
    logic                 state;
    logic [`RX_OSRW-1:0]  trgt;        // oldest open request
    logic                 hit;

    assign slot.cur_addr     = wr_ptr[slot.look_tag];
    assign slot.cur_saved    = saved[slot.look_tag];
    assign slot.cur_saved_en = saved_en[slot.look_tag];

    assign hit = slot.done && (slot.look_tag == trgt);

    // slot contents
    always_ff @(posedge clk) begin
        if (alloc.new_rq) begin
            st_ptr[alloc.tag]   <= alloc.base;
            wr_ptr[alloc.tag]   <= alloc.base;
            rq_len[alloc.tag]   <= alloc.len_qw;
            rcv_len[alloc.tag]  <= '0;
            saved_en[alloc.tag] <= 1'b0;
        end
        if (slot.upd) begin
            wr_ptr[slot.look_tag]   <= slot.upd_addr;
            rcv_len[slot.look_tag]  <= rcv_len[slot.look_tag] + slot.upd_rcv;
            saved[slot.look_tag]    <= slot.upd_saved;
            saved_en[slot.look_tag] <= slot.upd_saved_en;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // in-order commit
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= C_WAIT;
            trgt           <= '0;
            ready          <= '0;
            alloc.done_cnt <= '0;
            committed_prod <= '0;
        end else begin
            if (alloc.new_rq) ready[alloc.tag] <= 1'b0;
            if (slot.upd && !slot.done) ready[slot.look_tag] <= 1'b0;   // completion started
            if (slot.done) ready[slot.look_tag] <= 1'b1;
            case (state)
                C_WAIT: begin
                    if (hit || ready[trgt])
                        committed_prod <= hit ? slot.upd_addr : wr_ptr[trgt];
                    if (ready[trgt] && rcv_len[trgt] == {1'b0, rq_len[trgt]})
                        state <= C_RETIRE;
                end
                C_RETIRE: begin
                    committed_prod <= st_ptr[trgt] + PW'(rq_len[trgt]);
                    ready[trgt]    <= 1'b0;
                    trgt           <= trgt + 1'b1;
                    alloc.done_cnt <= alloc.done_cnt + 1'b1;
                    state          <= C_WAIT;
                end
            endcase
        end
    end

endmodule

// File: logic/rx_dma_top.sv
// Receive DMA top level
// host-to-card DMA for a 64-bit TRN endpoint: read request engine,
// completion filter, payload writer and in-order commit tracker
`include "rx_dma_defs.svh"

module rx_dma_top (
    input  logic                 clk,
    input  logic                 rst,
    // TRN receive
    input  logic [63:0]          trn_rd,
    input  logic                 trn_rsof_n,
    input  logic                 trn_reof_n,
    input  logic                 trn_rsrc_rdy_n,
    input  logic [2:0]           cfg_max_rd_req_size,
    // descriptor
    input  logic [63:0]          lbuf_addr,
    input  logic [31:0]          lbuf_len,
    input  logic                 lbuf_en,
    output logic                 lbuf_dn,
    // buffer pointers and write port
    output logic [`RX_BW:0]      committed_prod,
    input  logic [`RX_BW:0]      committed_cons,
    output logic                 wr_en,
    output logic [`RX_BW-1:0]    wr_addr,
    output logic [63:0]          wr_data,
    // memory read requests
    output logic [63:0]          hst_addr,
    output logic                 rd,
    output logic [8:0]           rd_qw,
    input  logic                 rd_ack,
    input  logic [`RX_OSRW-1:0]  rd_tag
);
    alloc_if alloc_i ();
    slot_if  slot_i ();

    logic                 cnsm;
    logic [9:0]           tlp_len;
    logic [`RX_OSRW-1:0]  tlp_tag;

    rd_req_engine engine_i (
        .clk, .rst, .cfg_max_rd_req_size, .lbuf_addr, .lbuf_len, .lbuf_en, .lbuf_dn,
        .committed_cons, .hst_addr, .rd, .rd_qw, .rd_ack, .rd_tag,
        .alloc (alloc_i.engine)
    );

    cpl_filter filter_i (
        .clk, .rst, .trn_rd, .trn_rsof_n, .trn_rsrc_rdy_n, .cnsm, .tlp_len, .tlp_tag
    );

    cpl_writer writer_i (
        .clk, .rst, .trn_rd, .trn_reof_n, .trn_rsrc_rdy_n, .cnsm, .tlp_len, .tlp_tag,
        .wr_en, .wr_addr, .wr_data,
        .slot (slot_i.writer)
    );

    cpl_tracker tracker_i (
        .clk, .rst, .committed_prod,
        .alloc (alloc_i.tracker),
        .slot  (slot_i.tracker)
    );

endmodule

// File: testbench/rx_dma_chk.sv
// Receive DMA protocol checks
// read handshake, done pulse width and write enable after reset
module rx_dma_chk (
    input logic clk,
    input logic rst,
    input logic rd,
    input logic rd_ack,
    input logic lbuf_dn,
    input logic wr_en
);
    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;   // failed assertions so far

    // a read stays up until the host takes it
    rd_hold: assert property (@(posedge clk) disable iff (rst) rd && !rd_ack |=> rd)
        else begin
            fails++;
            $error("rd dropped before rd_ack");
        end

    dn_pulse: assert property (@(posedge clk) disable iff (rst) lbuf_dn |=> !lbuf_dn)
        else begin
            fails++;
            $error("lbuf_dn held for more than one cycle");
        end

    wr_rst: assert property (@(posedge clk) rst |=> !wr_en)
        else begin
            fails++;
            $error("wr_en high right after reset");
        end

endmodule

bind rx_dma_top rx_dma_chk chk_i (.*);

// File: testbench/rx_dma_tb.sv
// Receive DMA testbench
// host memory and completer model, buffer model with in-order checks
`include "rx_dma_defs.svh"

module rx_dma_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PW    = `RX_BW + 1;
    localparam int DEPTH = 1 << `RX_BW;
    localparam int NTAG  = 1 << `RX_OSRW;
    localparam int HMEM  = 4096;

    logic                 clk;
    logic                 rst;
    logic [63:0]          trn_rd;
    logic                 trn_rsof_n;
    logic                 trn_reof_n;
    logic                 trn_rsrc_rdy_n;
    logic [2:0]           cfg_max_rd_req_size;
    logic [63:0]          lbuf_addr;
    logic [31:0]          lbuf_len;
    logic                 lbuf_en;
    logic                 lbuf_dn;
    logic [`RX_BW:0]      committed_prod;
    logic [`RX_BW:0]      committed_cons;
    logic                 wr_en;
    logic [`RX_BW-1:0]    wr_addr;
    logic [63:0]          wr_data;
    logic [63:0]          hst_addr;
    logic                 rd;
    logic [8:0]           rd_qw;
    logic                 rd_ack;
    logic [`RX_OSRW-1:0]  rd_tag;

    logic [63:0]   host_mem [HMEM];
    logic [63:0]   buf_mem [DEPTH];
    logic [DEPTH-1:0] written;
    logic [63:0]   exp_q [$];   // expected words in commit order
    int            rq_host [256];
    int            rq_len [256];
    logic [255:0]  rq_fin;
    int            n_req = 0;
    int            fin_seq = 0;
    int            fin_limit = 0;  // end of finished prefix in qw
    logic [PW-1:0] cons_ptr = '0;
    int            cons_abs = 0;
    logic          hold = 1'b0;
    logic          junk = 1'b0;
    logic [63:0]   exp_addr;
    int            exp_left = 0;
    int            exp_max = 16;
    int            host_ptr = 100;
    int            end_abs = 0;
    int            errors = 0;
    int            timeouts = 0;

    rx_dma_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected buffer word with the bytes of each dword reversed
    function automatic logic [63:0] ref_word(input int idx);
        logic [63:0] q;
        logic [63:0] r;
        q = host_mem[idx % HMEM];
        for (int b = 0; b < 8; b++)
            r[8*b +: 8] = q[8*((b/4)*4 + 3 - b%4) +: 8];
        return r;
    endfunction

    // payload dword k of a request as it goes on the link
    function automatic logic [31:0] pay_dw(input int seq, input int k);
        logic [63:0] q;
        q = host_mem[(rq_host[seq] + k/2) % HMEM];
        return k[0] ? q[63:32] : q[31:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host model answering reads and sending completions
    //////////////////////////////////////////////////////////////////////
    always begin : rd_responder
        int dly;
        int exp_qw;
        @(posedge clk);
        #1;
        if (!rst && rd) begin
            dly = $urandom_range(3);
            repeat (dly) begin
                @(posedge clk);
                #1;
            end
            exp_qw = (exp_left > exp_max) ? exp_max : exp_left;
            if (rd_qw !== 9'(exp_qw) || hst_addr !== exp_addr) begin
                errors++;
                $display("ERROR %0t: read of %0d qw at %h, expected %0d qw at %h",
                         $time, rd_qw, hst_addr, exp_qw, exp_addr);
            end
            exp_left -= exp_qw;
            exp_addr += 64'(exp_qw) << 3;
            rq_host[n_req] = int'(hst_addr >> 3);
            rq_len[n_req]  = int'(rd_qw);
            rq_fin[n_req]  = 1'b0;
            rd_ack = 1'b1;
            rd_tag = `RX_OSRW'(n_req % NTAG);
            n_req++;
            @(posedge clk);
            #1;
            rd_ack = 1'b0;
        end
    end

    task automatic drive_beat(input logic [63:0] d, input logic sof, input logic eof);
        @(posedge clk);
        #1;
        if ($urandom_range(7) == 0) begin   // idle beat now and then
            trn_rsrc_rdy_n = 1'b1;
            trn_rsof_n     = 1'b1;
            trn_reof_n     = 1'b1;
            @(posedge clk);
            #1;
        end
        trn_rd         = d;
        trn_rsof_n     = !sof;
        trn_reof_n     = !eof;
        trn_rsrc_rdy_n = 1'b0;
    endtask

    task automatic send_cpl(input int seq, input int first, input int n,
                            input logic [6:0] ft, input logic [2:0] st, input logic [7:0] tag8);
        int k;
        drive_beat({1'b0, ft, 14'h0, 10'(n), 16'h0100, st, 1'b0, 12'(4*n)}, 1'b1, 1'b0);
        drive_beat({16'h0000, tag8, 8'h00, pay_dw(seq, first)}, 1'b0, n == 1);
        k = 1;
        while (k < n) begin
            drive_beat({pay_dw(seq, first + k),
                        (k + 1 < n) ? pay_dw(seq, first + k + 1) : 32'h0}, 1'b0, k + 2 >= n);
            k += 2;
        end
        @(posedge clk);
        #1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    // whole request when a is 0, else parts of a, b and the rest in dwords
    task automatic send_parts(input int seq, input int a, input int b);
        int n;
        logic [7:0] tag8;
        n = 2 * rq_len[seq];
        tag8 = {`RX_TAG_BASE, `RX_OSRW'(seq % NTAG)};
        if (a == 0) a = n;
        send_cpl(seq, 0, a, `RX_CPLD_FMT_TYPE, `RX_CPL_SC, tag8);
        if (b > 0) send_cpl(seq, a, b, `RX_CPLD_FMT_TYPE, `RX_CPL_SC, tag8);
        if (a + b < n) send_cpl(seq, a + b, n - a - b, `RX_CPLD_FMT_TYPE, `RX_CPL_SC, tag8);
        rq_fin[seq] = 1'b1;
        while (fin_seq < n_req && rq_fin[fin_seq]) begin
            fin_limit += rq_len[fin_seq];
            fin_seq++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // buffer model, commit checks and consumer
    //////////////////////////////////////////////////////////////////////
    always begin : compare_proc
        int avail;
        int lim;
        int idx;
        logic [63:0] exp_w;
        @(posedge clk);
        #1;
        if (!rst && wr_en) begin
            if (junk) begin
                errors++;
                $display("ERROR %0t: write at %h from a dropped completion", $time, wr_addr);
            end
            buf_mem[wr_addr] = wr_data;
            written[wr_addr] = 1'b1;
        end
        avail = int'(PW'(committed_prod - cons_ptr));
        lim   = fin_limit + ((fin_seq < n_req) ? rq_len[fin_seq] : 0);
        if (!rst && cons_abs + avail > lim) begin
            errors++;
            $display("ERROR %0t: committed_prod at %0d passes oldest open request end %0d",
                     $time, cons_abs + avail, lim);
        end
        while (!rst && cons_ptr != committed_prod) begin
            idx = int'(cons_ptr[`RX_BW-1:0]);
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %0t: commit at %0d beyond issued data", $time, idx);
            end else begin
                exp_w = exp_q.pop_front();
                if (!written[idx] || buf_mem[idx] !== exp_w) begin
                    errors++;
                    $display("ERROR %0t: buffer[%0d] = %h (written %b), expected %h",
                             $time, idx, buf_mem[idx], written[idx], exp_w);
                end
            end
            written[idx] = 1'b0;
            cons_ptr++;
            cons_abs++;
        end
        if (!hold) committed_cons = cons_ptr;
    end

    //////////////////////////////////////////////////////////////////////
    // waits and sequences
    //////////////////////////////////////////////////////////////////////
    task automatic wait_dn(input int limit);
        int n;
        n = 0;
        while (!lbuf_dn && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!lbuf_dn) begin
            timeouts++;
            $display("timed out at %0t waiting for lbuf_dn", $time);
        end
    endtask

    task automatic wait_reqs(input int cnt, input int limit);
        int n;
        n = 0;
        while (n_req < cnt && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n_req < cnt) begin
            timeouts++;
            $display("timed out at %0t waiting for read %0d", $time, cnt);
        end
    endtask

    task automatic wait_abs(input int target, input int limit);
        int n;
        n = 0;
        while (cons_abs < target && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cons_abs < target) begin
            timeouts++;
            $display("timed out at %0t, committed %0d of %0d qw", $time, cons_abs, target);
        end else if (committed_prod !== PW'(target)) begin
            errors++;
            $display("ERROR %0t: committed_prod %0d, expected %0d", $time, committed_prod,
                     PW'(target));
        end
    endtask

    task automatic watch_no_rd(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (rd) begin
                errors++;
                $display("ERROR %0t: read raised without buffer space", $time);
            end
        end
    endtask

    task automatic start_desc(input int cfg, input int len, output int first);
        cfg_max_rd_req_size = 3'(cfg);
        lbuf_addr = 64'(host_ptr) << 3;
        lbuf_len  = 32'(len);
        exp_addr  = lbuf_addr;
        exp_left  = len;
        exp_max   = 1 << (`RX_MAX_QW_LOG + cfg);
        for (int i = 0; i < len; i++)
            exp_q.push_back(ref_word(host_ptr + i));
        host_ptr += len;
        first = n_req;
        @(posedge clk);
        #1;
        lbuf_en = 1'b1;
        @(posedge clk);
        #1;
        lbuf_en = 1'b0;
    endtask

    // mode 0 in order, 1 split at odd dwords, 2 reversed
    task automatic run_desc(input int cfg, input int len, input int mode);
        int first;
        int last;
        start_desc(cfg, len, first);
        wait_dn(4000);
        last = n_req - 1;
        for (int s = first; s <= last; s++) begin
            if (mode == 2) send_parts(last - (s - first), 0, 0);
            else if (mode == 0 || (s - first) % 3 == 0) send_parts(s, 0, 0);
            else if ((s - first) % 3 == 1) send_parts(s, 3, 0);
            else send_parts(s, 1, 4);   // single dword, even, odd tail
        end
        end_abs += len;
        wait_abs(end_abs, 4000);
    endtask

    initial begin
        int first;
        void'($urandom(32'h562c7ab3));
        rst = 1'b1;
        trn_rd = '0;
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        cfg_max_rd_req_size = 3'd0;
        lbuf_addr = '0;
        lbuf_len = '0;
        lbuf_en = 1'b0;
        committed_cons = '0;
        rd_ack = 1'b0;
        rd_tag = '0;
        written = '0;
        for (int i = 0; i < HMEM; i++)
            host_mem[i] = {$urandom, $urandom};
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        run_desc(2, 200, 0);
        run_desc(0, 70, 1);
        run_desc(1, 150, 2);

        // consumer held back so the fifth read has to wait for space
        hold = 1'b1;
        start_desc(3, 600, first);
        wait_reqs(first + 4, 4000);
        watch_no_rd(40);
        for (int s = first; s < first + 4; s++)
            send_parts(s, 0, 0);
        wait_abs(end_abs + 512, 4000);
        watch_no_rd(20);
        if (n_req != first + 4) begin
            errors++;
            $display("ERROR %0t: %0d reads issued while the buffer is full", $time, n_req - first);
        end
        hold = 1'b0;
        wait_dn(4000);
        for (int s = first + 4; s < n_req; s++)
            send_parts(s, 0, 0);
        end_abs += 600;
        wait_abs(end_abs, 4000);

        // foreign tag, error status, no data
        junk = 1'b1;
        send_cpl(0, 0, 4, `RX_CPLD_FMT_TYPE, `RX_CPL_SC, {`RX_TAG_BASE ^ 5'b10000, 3'd0});
        send_cpl(0, 0, 4, `RX_CPLD_FMT_TYPE, 3'b001, {`RX_TAG_BASE, 3'd0});
        send_cpl(0, 0, 2, 7'b0001010, `RX_CPL_SC, {`RX_TAG_BASE, 3'd1});
        repeat (8) @(posedge clk);
        #1;
        junk = 1'b0;
        if (committed_prod !== PW'(end_abs)) begin
            errors++;
            $display("ERROR %0t: committed_prod moved to %0d on dropped completions", $time,
                     committed_prod);
        end

        $display("%0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut_i.chk_i.fails);
        if (errors == 0 && timeouts == 0 && dut_i.chk_i.fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/rx_dma_pkg.sv
logic/rx_dma_if.sv
logic/rd_req_engine.sv
logic/cpl_filter.sv
logic/cpl_writer.sv
logic/cpl_tracker.sv
logic/rx_dma_top.sv
testbench/rx_dma_chk.sv
testbench/rx_dma_tb.sv
+incdir+logic
